// ==== hw/axi_ram.sv ====
// axi4 slave over an 8 KiB ram; no narrow transfers, no exclusive access, bresp always okay
`timescale 1ns/1ps
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_ram
    import axi_ram_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`AXI_ID_W-1:0]     arid,
    input  wire [`AXI_ADDR_W-1:0]   araddr,
    input  wire [7:0]               arlen,
    input  wire [2:0]               arsize,
    input  wire [1:0]               arburst,
    input  wire                     arvalid,
    output logic                    arready,
    output logic [`AXI_ID_W-1:0]    rid,
    output logic [`AXI_DATA_W-1:0]  rdata,
    output logic [1:0]              rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  wire                     rready,
    input  wire [`AXI_ID_W-1:0]     awid,
    input  wire [`AXI_ADDR_W-1:0]   awaddr,
    input  wire [7:0]               awlen,
    input  wire [2:0]               awsize,
    input  wire [1:0]               awburst,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire [`AXI_DATA_W-1:0]   wdata,
    input  wire [`AXI_STRB_W-1:0]   wstrb,
    input  wire                     wlast,
    input  wire                     wvalid,
    output logic                    wready,
    output logic [`AXI_ID_W-1:0]    bid,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  wire                     bready
);

    localparam int DL = `CH_FIFO_DEPTH_LOG2;

    axi_req_t             ar_in, ar_head, aw_in, aw_head;
    axi_w_t               w_in, w_head;
    axi_r_t               r_beat, r_out;
    logic                 ar_empty, ar_full, ar_pop;
    logic                 aw_empty, aw_full, aw_pop;
    logic                 w_empty, w_full, w_pop;
    logic                 r_empty, r_almost_full, r_push;
    logic                 b_empty, b_full, b_push;
    logic [`AXI_ID_W-1:0] b_id;

    assign ar_in = '{id: arid, addr: araddr, len: arlen, size: arsize, burst: burst_e'(arburst)};
    assign aw_in = '{id: awid, addr: awaddr, len: awlen, size: awsize, burst: burst_e'(awburst)};
    assign w_in  = '{data: wdata, strb: wstrb, last: wlast};

    sync_fifo #(.WIDTH($bits(axi_req_t)), .DEPTH_LOG2(DL)) ar_fifo (
        .clk(clk), .rst_n(rst_n), .push(arvalid && arready), .din(ar_in), .pop(ar_pop),
        .dout(ar_head), .empty(ar_empty), .full(ar_full), .almost_full()
    );

    sync_fifo #(.WIDTH($bits(axi_req_t)), .DEPTH_LOG2(DL)) aw_fifo (
        .clk(clk), .rst_n(rst_n), .push(awvalid && awready), .din(aw_in), .pop(aw_pop),
        .dout(aw_head), .empty(aw_empty), .full(aw_full), .almost_full()
    );

    sync_fifo #(.WIDTH($bits(axi_w_t)), .DEPTH_LOG2(DL)) w_fifo (
        .clk(clk), .rst_n(rst_n), .push(wvalid && wready), .din(w_in), .pop(w_pop),
        .dout(w_head), .empty(w_empty), .full(w_full), .almost_full()
    );

    sync_fifo #(.WIDTH($bits(axi_r_t)), .DEPTH_LOG2(DL)) r_fifo (
        .clk(clk), .rst_n(rst_n), .push(r_push), .din(r_beat), .pop(rvalid && rready),
        .dout(r_out), .empty(r_empty), .full(), .almost_full(r_almost_full)
    );

    sync_fifo #(.WIDTH(`AXI_ID_W), .DEPTH_LOG2(DL)) b_fifo (
        .clk(clk), .rst_n(rst_n), .push(b_push), .din(b_id), .pop(bvalid && bready),
        .dout(bid), .empty(b_empty), .full(b_full), .almost_full()
    );

    axi_ram_engine u_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .ar_head       (ar_head),
        .ar_empty      (ar_empty),
        .ar_pop        (ar_pop),
        .aw_head       (aw_head),
        .aw_empty      (aw_empty),
        .aw_pop        (aw_pop),
        .w_head        (w_head),
        .w_empty       (w_empty),
        .w_pop         (w_pop),
        .r_beat        (r_beat),
        .r_push        (r_push),
        .r_almost_full (r_almost_full),
        .b_id          (b_id),
        .b_push        (b_push),
        .b_full        (b_full)
    );

    assign arready = !ar_full;
    assign awready = !aw_full;
    assign wready  = !w_full;

    assign rvalid = !r_empty;
    assign rid    = r_out.id;
    assign rdata  = r_out.data;
    assign rresp  = r_out.resp;
    assign rlast  = r_out.last;

    assign bvalid = !b_empty;
    assign bresp  = RESP_OKAY;

endmodule

`default_nettype wire

// ==== hw/axi_ram_cfg.svh ====
// widths and depths for the axi ram slave; data width is fixed at 64 bits and depths are log2
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

// axi bus widths
`define AXI_ADDR_W 32
`define AXI_ID_W   4
`define AXI_DATA_W 64
`define AXI_STRB_W 8

// ram holds 2**RAM_WORDS_LOG2 words of 8 bytes
`define RAM_WORDS_LOG2 10

// every channel fifo gets the same depth
`define CH_FIFO_DEPTH_LOG2 2

`endif

// ==== hw/axi_ram_engine.sv ====
// one burst at a time, read before write; wlast is ignored and a write waits while b fifo is full
`timescale 1ns/1ps
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_ram_engine
    import axi_ram_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire axi_req_t       ar_head,
    input  wire                 ar_empty,
    output logic                ar_pop,
    input  wire axi_req_t       aw_head,
    input  wire                 aw_empty,
    output logic                aw_pop,
    input  wire axi_w_t         w_head,
    input  wire                 w_empty,
    output logic                w_pop,
    output axi_r_t              r_beat,
    output logic                r_push,
    input  wire                 r_almost_full,
    output logic [`AXI_ID_W-1:0] b_id,
    output logic                b_push,
    input  wire                 b_full
);

    localparam int AW       = `AXI_ADDR_W;
    localparam int WORD_LSB = 3;
    localparam int WORD_MSB = `RAM_WORDS_LOG2 + 2;

    engine_state_e          state_q;
    engine_state_e          state_d;
    logic                   start_rd;
    logic                   start_wr;
    axi_req_t               gen_req;
    logic [AW-1:0]          gen_addr;
    logic                   gen_last;
    logic                   gen_done;
    logic                   in_range;
    logic                   rd_issue;
    logic                   wr_beat;
    logic [`AXI_DATA_W-1:0] ram_rdata;
    logic                   rd_vld_q;
    logic                   rd_last_q;
    resp_e                  rd_resp_q;
    logic [`AXI_ID_W-1:0]   rd_id_q;

    assign start_rd = (state_q == ENG_IDLE) && !ar_empty;
    assign start_wr = (state_q == ENG_IDLE) && ar_empty && !aw_empty && !b_full;
    assign gen_req  = start_rd ? ar_head : aw_head;
    assign in_range = ~|gen_addr[AW-1:WORD_MSB+1];  // below 8 KiB

    assign rd_issue = (state_q == ENG_READ) && !gen_done && !r_almost_full;
    assign wr_beat  = (state_q == ENG_WRITE) && !gen_done && !w_empty;

    burst_addr_gen u_addr_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (start_rd || start_wr),
        .req   (gen_req),
        .step  (rd_issue || wr_beat),
        .addr  (gen_addr),
        .last  (gen_last),
        .done  (gen_done)
    );

    byte_ram u_ram (
        .clk       (clk),
        .rd_en     (rd_issue),
        .wr_en     (wr_beat && in_range),  // out-of-range writes vanish
        .word_addr (gen_addr[WORD_MSB:WORD_LSB]),
        .wdata     (w_head.data),
        .wstrb     (w_head.strb),
        .rdata     (ram_rdata)
    );

    // beat info lines up with the registered ram output
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_last_q <= gen_last;
            rd_id_q   <= ar_head.id;
            rd_resp_q <= (ar_head.size > 3'd3 || !in_range) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ENG_IDLE: begin
                if (start_rd) begin
                    state_d = ENG_READ;
                end else if (start_wr) begin
                    state_d = ENG_WRITE;
                end
            end
            ENG_READ: begin
                if (rd_vld_q && rd_last_q) begin
                    state_d = ENG_IDLE;
                end
            end
            ENG_WRITE: begin
                if (wr_beat && gen_last) begin
                    state_d = ENG_IDLE;
                end
            end
            default: state_d = ENG_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ENG_IDLE;
            rd_vld_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            rd_vld_q <= rd_issue;
        end
    end

    assign r_push = rd_vld_q;
    assign r_beat = '{id: rd_id_q, data: ram_rdata, resp: rd_resp_q, last: rd_last_q};
    assign ar_pop = (state_q == ENG_READ) && rd_vld_q && rd_last_q;

    assign w_pop  = wr_beat;
    assign aw_pop = wr_beat && gen_last;
    assign b_push = wr_beat && gen_last;  // b fifo has room, checked at start
    assign b_id   = aw_head.id;

endmodule

`default_nettype wire

// ==== hw/axi_ram_pkg.sv ====
// types for the axi ram slave; struct field order sets the bit packing inside the channel fifos
`default_nettype none

`include "axi_ram_cfg.svh"

package axi_ram_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2,
        BURST_RSVD  = 2'd3  // served like fixed
    } burst_e;

    typedef enum logic [1:0] {
        ENG_IDLE  = 2'd0,
        ENG_READ  = 2'd1,
        ENG_WRITE = 2'd2
    } engine_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    // one ar or aw request
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        burst_e                 burst;
    } axi_req_t;

    // one w beat
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    // one r beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
        logic                   last;
    } axi_r_t;

endpackage

`default_nettype wire

// ==== hw/burst_addr_gen.sv ====
// beat address generator; steps are always 8 bytes, wrap is only valid for 2, 4, 8 or 16 beats
`timescale 1ns/1ps
`default_nettype none

`include "axi_ram_cfg.svh"

module burst_addr_gen
    import axi_ram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load,
    input  wire axi_req_t          req,
    input  wire                    step,
    output logic [`AXI_ADDR_W-1:0] addr,
    output logic                   last,
    output logic                   done
);

    localparam int AW = `AXI_ADDR_W;
    localparam logic [AW-1:0] BEAT_BYTES = AW'(8);

    logic [AW-1:0] addr_q;
    logic [7:0]    len_q;
    burst_e        burst_q;
    logic [8:0]    remain_q;
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] addr_inc;
    logic [AW-1:0] addr_next;

    // len is all ones for legal wrap lengths, so this is (len+1)*8-1
    assign wrap_mask = {{(AW-11){1'b0}}, len_q, 3'b111};
    assign addr_inc  = addr_q + BEAT_BYTES;

    always_comb begin
        case (burst_q)
            BURST_INCR: addr_next = addr_inc;
            BURST_WRAP: addr_next = (addr_q & ~wrap_mask) | (addr_inc & wrap_mask);
            default:    addr_next = addr_q;  // fixed and reserved
        endcase
    end

    // running address and length travel with the burst
    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= {req.addr[AW-1:3], 3'b000};
            len_q  <= req.len;
        end else if (step) begin
            addr_q <= addr_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_q  <= BURST_FIXED;
            remain_q <= '0;
        end else if (load) begin
            burst_q  <= req.burst;
            remain_q <= {1'b0, req.len} + 9'd1;
        end else if (step && remain_q != '0) begin
            remain_q <= remain_q - 9'd1;
        end
    end

    assign addr = addr_q;
    assign last = (remain_q == 9'd1);
    assign done = (remain_q == 9'd0);

endmodule

`default_nettype wire

// ==== hw/byte_ram.sv ====
// single-port word ram, no reset on contents; read data appears one cycle after rd_en
`timescale 1ns/1ps
`default_nettype none

`include "axi_ram_cfg.svh"

module byte_ram (
    input  wire                       clk,
    input  wire                       rd_en,
    input  wire                       wr_en,
    input  wire [`RAM_WORDS_LOG2-1:0] word_addr,
    input  wire [`AXI_DATA_W-1:0]     wdata,
    input  wire [`AXI_STRB_W-1:0]     wstrb,
    output logic [`AXI_DATA_W-1:0]    rdata
);

    localparam int WORDS = 1 << `RAM_WORDS_LOG2;

    logic [`AXI_DATA_W-1:0] mem [WORDS];

    // byte lanes update only where the strobe is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[word_addr];  // holds last read otherwise
        end
    end

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
// show-ahead fifo; push when full and pop when empty are ignored, no overflow flag
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              push,
    input  wire [WIDTH-1:0]  din,
    input  wire              pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty       = (count == '0);
    assign full        = (count == DEPTH[DEPTH_LOG2:0]);
    assign almost_full = (count >= DEPTH[DEPTH_LOG2:0] - 1'b1);  // one slot or none left
    assign dout        = mem[rd_ptr];                             // head visible when not empty

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_axi_ram -f sim.f

out=$(./obj_dir/Vtb_axi_ram)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+hw
hw/axi_ram_pkg.sv
hw/sync_fifo.sv
hw/burst_addr_gen.sv
hw/byte_ram.sv
hw/axi_ram_engine.sv
hw/axi_ram.sv
verif/tb_axi_ram.sv

// ==== verif/tb_axi_ram.sv ====
// one burst at a time with awsize 3; the whole ram is written first so every read has a known model
`timescale 1ns/1ps
`default_nettype none

`include "axi_ram_cfg.svh"

module tb_axi_ram
    import axi_ram_pkg::*;
();

    localparam int IDW       = `AXI_ID_W;
    localparam int MSB       = `RAM_WORDS_LOG2 + 2;
    localparam int RAM_BYTES = 1 << (MSB + 1);
    localparam int TIMEOUT   = 1000;

    logic clk, rst_n;
    logic [IDW-1:0] arid, awid, rid, bid;
    logic [`AXI_ADDR_W-1:0] araddr, awaddr;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst, rresp, bresp;
    logic [`AXI_DATA_W-1:0] wdata, rdata;
    logic [`AXI_STRB_W-1:0] wstrb;
    logic arvalid, arready, awvalid, awready, wvalid, wready, wlast;
    logic rvalid, rready, rlast, bvalid, bready;

    axi_req_t    ar_req, aw_req;
    axi_w_t      w_beat;
    logic [15:0] lfsr = 16'd22928;
    logic [7:0]  model_mem [RAM_BYTES];
    int          checks = 0;
    int          errors = 0;
    int          stall  = 1;     // random bits per ready decision, 0 keeps ready high
    logic        hung   = 1'b0;

    assign {arid, araddr, arlen, arsize, arburst} = ar_req;
    assign {awid, awaddr, awlen, awsize, awburst} = aw_req;
    assign {wdata, wstrb, wlast} = w_beat;

    axi_ram DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] next_addr(input logic [31:0] a, input logic [7:0] len,
                                              input burst_e burst);
        logic [31:0] mask;
        mask = ((32'(len) + 32'd1) << 3) - 32'd1;  // wrap block of (len+1)*8 bytes
        case (burst)
            BURST_INCR: return a + 32'd8;
            BURST_WRAP: return (a & ~mask) | ((a + 32'd8) & mask);
            default:    return a;
        endcase
    endfunction

    function automatic logic [63:0] model_word(input logic [31:0] a);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = model_mem[int'(a[MSB:3]) * 8 + b];
        end
        return w;
    endfunction

    function automatic logic chan_ok(input int ch);
        case (ch)
            0:       return arready;
            1:       return awready;
            2:       return wready;
            3:       return rvalid && rready;
            default: return bvalid && bready;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (!hung) begin
            assert (exp === act) else begin
                errors++;
                $display("ERROR %s: expected %h, actual %h", name, exp, act);
            end
        end
    endtask

    // new ready levels at the rising edge, handshake seen at the falling edge
    task automatic wait_for(input int ch, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!chan_ok(ch) && n < TIMEOUT && !hung) begin
            @(posedge clk);
            rready <= (rand_bits(stall) == '0);
            bready <= (rand_bits(stall) == '0);
            @(negedge clk);
            n++;
        end
        if (!chan_ok(ch) && !hung) begin
            hung = 1'b1;
            errors++;
            $display("timeout: the DUT never completed %s", what);
        end
    endtask

    task automatic write_burst(input string name, input logic [31:0] addr, input logic [7:0] len,
                               input burst_e burst, input logic all_strb);
        logic [31:0]    a;
        logic [IDW-1:0] id;
        logic [63:0]    d;
        logic [7:0]     s;
        id = IDW'(rand_bits(IDW));
        @(posedge clk);
        aw_req  <= '{id: id, addr: addr, len: len, size: 3'd3, burst: burst};
        awvalid <= 1'b1;
        wait_for(1, "the AW handshake");
        @(posedge clk);
        awvalid <= 1'b0;
        a = addr & ~32'd7;
        for (int i = 0; i <= int'(len); i++) begin
            d = rand_bits(64);
            s = all_strb ? 8'hFF : 8'(rand_bits(8));
            w_beat <= '{data: d, strb: s, last: (i == int'(len))};
            wvalid <= 1'b1;
            wait_for(2, "a W handshake");
            @(posedge clk);
            for (int b = 0; b < 8; b++) begin
                if (s[b] && a < 32'(RAM_BYTES)) begin
                    model_mem[int'(a[MSB:3]) * 8 + b] = d[b*8 +: 8];
                end
            end
            a = next_addr(a, len, burst);
        end
        wvalid <= 1'b0;
        wait_for(4, "the B response");
        check_value({name, " bid"}, 64'(id), 64'(bid));
        check_value({name, " bresp"}, 64'(RESP_OKAY), 64'(bresp));
    endtask

    task automatic read_burst(input string name, input logic [31:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input burst_e burst);
        logic [31:0]    a;
        logic [IDW-1:0] id;
        logic [1:0]     resp;
        int             beats;
        id = IDW'(rand_bits(IDW));
        @(posedge clk);
        ar_req  <= '{id: id, addr: addr, len: len, size: size, burst: burst};
        arvalid <= 1'b1;
        wait_for(0, "the AR handshake");
        @(posedge clk);
        arvalid <= 1'b0;
        a     = addr & ~32'd7;
        beats = 0;
        do begin
            wait_for(3, "an R beat");
            resp = (size > 3'd3 || a >= 32'(RAM_BYTES)) ? RESP_SLVERR : RESP_OKAY;
            check_value({name, " rid"}, 64'(id), 64'(rid));
            check_value({name, " rresp"}, 64'(resp), 64'(rresp));
            check_value({name, " rlast"}, 64'(beats == int'(len)), 64'(rlast));
            if (resp == RESP_OKAY) begin
                check_value({name, " rdata"}, model_word(a), rdata);
            end
            a = next_addr(a, len, burst);
            beats++;
        end while (!rlast && !hung && beats <= int'(len));
    endtask

    initial begin
        logic [31:0] base;
        logic [7:0]  len;
        rst_n   = 1'b0;
        ar_req  = '0;
        aw_req  = '0;
        w_beat  = '0;
        arvalid = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        rready  = 1'b0;
        bready  = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);
        check_value("reset levels", 64'b00111, 64'({rvalid, bvalid, arready, awready, wready}));

        for (int i = 0; i < RAM_BYTES; i += 128) begin
            write_burst("fill", 32'(i), 8'd15, BURST_INCR, 1'b1);
        end

        for (int t = 0; t < 12; t++) begin
            base = 32'(rand_bits(12));  // unaligned start in the low half
            len  = 8'(rand_bits(4));
            write_burst("incr", base, len, BURST_INCR, 1'b0);
            read_burst("incr", base, len, 3'd3, BURST_INCR);
            len  = (rand_bits(1) == '0) ? 8'd3 : 8'd7;
            base = (32'(rand_bits(7)) << 6) | ((32'(len) + 32'd1) << 2);  // middle of the block
            write_burst("wrap", base, len, BURST_WRAP, 1'b0);
            read_burst("wrap", base, len, 3'd3, BURST_WRAP);
            read_burst("wrap block", base & ~((32'(len) << 3) | 32'd7), len, 3'd3, BURST_INCR);
            base = 32'(rand_bits(13));
            write_burst("fixed", base, 8'd3, BURST_FIXED, 1'b0);
            read_burst("fixed", base, 8'd3, 3'd3, BURST_FIXED);
        end

        read_burst("size error", 32'h0000_0100, 8'd3, 3'd4, BURST_INCR);
        read_burst("range error", 32'h0000_1FF0, 8'd3, 3'd3, BURST_INCR);  // last two beats past 8 KiB
        write_burst("range write", 32'h0000_2040, 8'd3, BURST_INCR, 1'b0);
        read_burst("range write", 32'h0000_0040, 8'd3, 3'd3, BURST_INCR);  // aliased word untouched

        stall = 3;
        for (int t = 0; t < 3; t++) begin
            base = 32'(rand_bits(12));
            write_burst("stall", base, 8'd15, BURST_INCR, 1'b0);
            read_burst("stall", base, 8'd15, 3'd3, BURST_INCR);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
